// File: design/isa_pkg.sv
package isa_pkg;

    localparam int OP_WIDTH    = 6;
    localparam int FUNCT_WIDTH = 6;

    // Opcodes
    localparam logic [OP_WIDTH-1:0] OP_RTYPE = 6'h00;
    localparam logic [OP_WIDTH-1:0] OP_J     = 6'h02;
    localparam logic [OP_WIDTH-1:0] OP_JAL   = 6'h03;
    localparam logic [OP_WIDTH-1:0] OP_BEQ   = 6'h04;
    localparam logic [OP_WIDTH-1:0] OP_BNE   = 6'h05;
    localparam logic [OP_WIDTH-1:0] OP_BLE   = 6'h06;
    localparam logic [OP_WIDTH-1:0] OP_BGT   = 6'h07;
    localparam logic [OP_WIDTH-1:0] OP_ADDI  = 6'h08;
    localparam logic [OP_WIDTH-1:0] OP_ADDIU = 6'h09;

    // Funct codes under OP_RTYPE
    localparam logic [FUNCT_WIDTH-1:0] FN_JR   = 6'h08;
    localparam logic [FUNCT_WIDTH-1:0] FN_MFHI = 6'h10;
    localparam logic [FUNCT_WIDTH-1:0] FN_MFLO = 6'h12;
    localparam logic [FUNCT_WIDTH-1:0] FN_MULT = 6'h18;
    localparam logic [FUNCT_WIDTH-1:0] FN_DIV  = 6'h1a;
    localparam logic [FUNCT_WIDTH-1:0] FN_ADD  = 6'h20;
    localparam logic [FUNCT_WIDTH-1:0] FN_SUB  = 6'h22;
    localparam logic [FUNCT_WIDTH-1:0] FN_AND  = 6'h24;

    typedef enum logic [4:0] {
        CLS_ADD,
        CLS_SUB,
        CLS_AND,
        CLS_ADDI,
        CLS_ADDIU,
        CLS_BEQ,
        CLS_BNE,
        CLS_BGT,
        CLS_BLE,
        CLS_J,
        CLS_JAL,
        CLS_JR,
        CLS_MULT,
        CLS_DIV,
        CLS_MFHI,
        CLS_MFLO,
        CLS_INVALID
    } instr_class_t;

endpackage

// File: design/ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [5:0] {
        FETCH1, FETCH2,
        DECODE1, DECODE2, DECODE3, DECODE4,
        ALU_R, ALU_I, SAVE_R, SAVE_I,
        BRANCH,
        JUMP, JAL1, JAL2, JR1, JR2,
        MUL_START, MUL_WAIT, MUL_DONE,
        DIV_START, DIV_WAIT, DIV_DONE,
        MFHI, MFLO,
        EXC_SAVE, EXC_ADDR, EXC_WAIT, EXC_LOAD, EXC_JUMP
    } state_t;

    typedef enum logic [1:0] {
        EXC_OPCODE,
        EXC_OVERFLOW,
        EXC_DIVZERO
    } exc_cause_t;

    // ALU operations
    localparam logic [2:0] ALU_PASS = 3'b000;
    localparam logic [2:0] ALU_ADD  = 3'b001;
    localparam logic [2:0] ALU_SUB  = 3'b010;
    localparam logic [2:0] ALU_AND  = 3'b011;
    localparam logic [2:0] ALU_CMP  = 3'b111;

    localparam logic [1:0] BR_EQ = 2'b00;
    localparam logic [1:0] BR_NE = 2'b01;
    localparam logic [1:0] BR_GT = 2'b10;
    localparam logic [1:0] BR_LE = 2'b11;

    // Memory address mux, vectors sit at fixed addresses
    localparam logic [2:0] IORD_PC           = 3'b000;
    localparam logic [2:0] IORD_VEC_OPCODE   = 3'b010;
    localparam logic [2:0] IORD_VEC_OVERFLOW = 3'b011;
    localparam logic [2:0] IORD_VEC_DIVZERO  = 3'b100;

    localparam logic [2:0] PCSRC_ALU    = 3'b000;
    localparam logic [2:0] PCSRC_ALUOUT = 3'b001;
    localparam logic [2:0] PCSRC_JUMP   = 3'b010;
    localparam logic [2:0] PCSRC_EXC    = 3'b110; // Vector from MDR

    localparam logic [2:0] REGDST_RT = 3'b000;
    localparam logic [2:0] REGDST_SP = 3'b001;
    localparam logic [2:0] REGDST_RA = 3'b010;
    localparam logic [2:0] REGDST_RD = 3'b011;

    localparam logic [3:0] MEMTOREG_ALUOUT  = 4'b0000;
    localparam logic [3:0] MEMTOREG_HI      = 4'b0010;
    localparam logic [3:0] MEMTOREG_LO      = 4'b0011;
    localparam logic [3:0] MEMTOREG_SP_INIT = 4'b0101;

    localparam logic [1:0] SRCB_B      = 2'b00;
    localparam logic [1:0] SRCB_FOUR   = 2'b01;
    localparam logic [1:0] SRCB_IMM    = 2'b10;
    localparam logic [1:0] SRCB_OFFSET = 2'b11; // Immediate shifted left by 2

endpackage

// File: design/instr_decoder.sv
module instr_decoder
    import isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [OP_WIDTH-1:0]    op,
    input  logic [FUNCT_WIDTH-1:0] funct,
    output instr_class_t           instr_class
);

    instr_class_t class_next;

    always_comb begin
        case (op)
            OP_RTYPE: begin
                case (funct)
                    FN_ADD:  class_next = CLS_ADD;
                    FN_SUB:  class_next = CLS_SUB;
                    FN_AND:  class_next = CLS_AND;
                    FN_MULT: class_next = CLS_MULT;
                    FN_DIV:  class_next = CLS_DIV;
                    FN_JR:   class_next = CLS_JR;
                    FN_MFHI: class_next = CLS_MFHI;
                    FN_MFLO: class_next = CLS_MFLO;
                    default: class_next = CLS_INVALID;
                endcase
            end
            OP_ADDI:  class_next = CLS_ADDI;
            OP_ADDIU: class_next = CLS_ADDIU;
            OP_BEQ:   class_next = CLS_BEQ;
            OP_BNE:   class_next = CLS_BNE;
            OP_BGT:   class_next = CLS_BGT;
            OP_BLE:   class_next = CLS_BLE;
            OP_J:     class_next = CLS_J;
            OP_JAL:   class_next = CLS_JAL;
            default:  class_next = CLS_INVALID;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instr_class <= CLS_INVALID;
        end else begin
            instr_class <= class_next;
        end
    end

endmodule

// File: design/cycle_sequencer.sv
module cycle_sequencer
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  instr_class_t instr_class,
    input  logic         overflow,
    input  logic         mult_stop,
    input  logic         div_stop,
    input  logic         div_zero,
    output state_t       state,
    output exc_cause_t   exc_cause
);

    state_t     state_next;
    exc_cause_t cause_q;
    logic       ovf_trap;

    // ADDIU ignores overflow
    assign ovf_trap = overflow &&
        (state == SAVE_R || (state == SAVE_I && instr_class == CLS_ADDI));

    // exc_cause shows the cause being taken in the same cycle
    always_comb begin
        state_next = state;
        exc_cause  = cause_q;
        case (state)
            FETCH1:  state_next = FETCH2;
            FETCH2:  state_next = DECODE1;
            DECODE1: state_next = DECODE2;
            DECODE2: state_next = DECODE3;
            DECODE3: state_next = DECODE4;
            DECODE4: begin
                exc_cause = EXC_OPCODE; // Only cause possible from decode
                case (instr_class)
                    CLS_ADD, CLS_SUB, CLS_AND:          state_next = ALU_R;
                    CLS_ADDI, CLS_ADDIU:                state_next = ALU_I;
                    CLS_BEQ, CLS_BNE, CLS_BGT, CLS_BLE: state_next = BRANCH;
                    CLS_J:                              state_next = JUMP;
                    CLS_JAL:                            state_next = JAL1;
                    CLS_JR:                             state_next = JR1;
                    CLS_MULT:                           state_next = MUL_START;
                    CLS_DIV:                            state_next = DIV_START;
                    CLS_MFHI:                           state_next = MFHI;
                    CLS_MFLO:                           state_next = MFLO;
                    default:                            state_next = EXC_SAVE;
                endcase
            end
            ALU_R: state_next = SAVE_R;
            ALU_I: state_next = SAVE_I;
            SAVE_R, SAVE_I: begin
                if (ovf_trap) begin
                    state_next = EXC_SAVE;
                    exc_cause  = EXC_OVERFLOW;
                end else begin
                    state_next = FETCH1;
                end
            end
            JAL1:      state_next = JAL2;
            JAL2:      state_next = JUMP; // Link written, now jump
            JR1:       state_next = JR2;
            MUL_START: state_next = MUL_WAIT;
            MUL_WAIT: begin
                if (mult_stop) begin
                    state_next = MUL_DONE;
                end
            end
            DIV_START: state_next = DIV_WAIT;
            DIV_WAIT: begin
                if (div_zero) begin
                    state_next = EXC_SAVE;
                    exc_cause  = EXC_DIVZERO;
                end else if (div_stop) begin
                    state_next = DIV_DONE;
                end
            end
            EXC_SAVE: state_next = EXC_ADDR;
            EXC_ADDR: state_next = EXC_WAIT;
            EXC_WAIT: state_next = EXC_LOAD; // Memory read latency
            EXC_LOAD: state_next = EXC_JUMP;
            default:  state_next = FETCH1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= FETCH1;
            cause_q <= EXC_OPCODE;
        end else begin
            state   <= state_next;
            cause_q <= exc_cause;
        end
    end

endmodule

// File: design/control_word_gen.sv
module control_word_gen
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  state_t       state,
    input  exc_cause_t   exc_cause,
    input  instr_class_t instr_class,
    output logic         ab_load,
    output logic         wr,
    output logic         regwrite,
    output logic         sel_ir,
    output logic         epc_load,
    output logic         aluout_load,
    output logic         hilo_load,
    output logic         mdr_load,
    output logic         pc_write_cond,
    output logic         pc_write,
    output logic         sel_regread,
    output logic         sel_alusrca,
    output logic         sel_mux_hi,
    output logic         sel_mux_lo,
    output logic         div_control,
    output logic         mult_control,
    output logic [2:0]   sel_aluop,
    output logic [1:0]   sel_alusrcb,
    output logic [1:0]   sel_branchop,
    output logic [2:0]   sel_pc_source,
    output logic [2:0]   sel_mux_iord,
    output logic [2:0]   sel_reg_dst,
    output logic [3:0]   sel_mux_mem_to_reg
);

    always_ff @(posedge clk) begin
        if (reset) begin
            // Stack pointer init write
            regwrite           <= 1'b1;
            sel_reg_dst        <= REGDST_SP;
            sel_mux_mem_to_reg <= MEMTOREG_SP_INIT;
            ab_load            <= 1'b0;
            wr                 <= 1'b0;
            sel_ir             <= 1'b0;
            epc_load           <= 1'b0;
            aluout_load        <= 1'b0;
            hilo_load          <= 1'b0;
            mdr_load           <= 1'b0;
            pc_write_cond      <= 1'b0;
            pc_write           <= 1'b0;
            div_control        <= 1'b0;
            mult_control       <= 1'b0;
            sel_regread        <= 1'b0;
            sel_alusrca        <= 1'b0;
            sel_mux_hi         <= 1'b0;
            sel_mux_lo         <= 1'b0;
            sel_aluop          <= ALU_PASS;
            sel_alusrcb        <= SRCB_B;
            sel_branchop       <= BR_EQ;
            sel_pc_source      <= PCSRC_ALU;
            sel_mux_iord       <= IORD_PC;
        end else begin
            // Enables are single-cycle pulses, selects hold
            ab_load       <= 1'b0;
            wr            <= 1'b0;
            regwrite      <= 1'b0;
            sel_ir        <= 1'b0;
            epc_load      <= 1'b0;
            aluout_load   <= 1'b0;
            hilo_load     <= 1'b0;
            mdr_load      <= 1'b0;
            pc_write_cond <= 1'b0;
            pc_write      <= 1'b0;
            div_control   <= 1'b0;
            mult_control  <= 1'b0;
            case (state)
                FETCH1: sel_mux_iord <= IORD_PC;
                FETCH2: begin
                    sel_alusrca   <= 1'b0;
                    sel_alusrcb   <= SRCB_FOUR; // PC + 4
                    sel_aluop     <= ALU_ADD;
                    sel_pc_source <= PCSRC_ALU;
                    pc_write      <= 1'b1;
                end
                DECODE1: begin
                    sel_ir      <= 1'b1;
                    sel_regread <= 1'b0;
                end
                DECODE2: ab_load <= 1'b1;
                DECODE3: begin
                    // Branch target computed ahead of time
                    sel_alusrca <= 1'b0;
                    sel_alusrcb <= SRCB_OFFSET;
                    sel_aluop   <= ALU_ADD;
                    aluout_load <= 1'b1;
                end
                ALU_R: begin
                    sel_alusrca <= 1'b1;
                    sel_alusrcb <= SRCB_B;
                    aluout_load <= 1'b1;
                    case (instr_class)
                        CLS_SUB: sel_aluop <= ALU_SUB;
                        CLS_AND: sel_aluop <= ALU_AND;
                        default: sel_aluop <= ALU_ADD;
                    endcase
                end
                ALU_I: begin
                    sel_alusrca <= 1'b1;
                    sel_alusrcb <= SRCB_IMM;
                    sel_aluop   <= ALU_ADD;
                    aluout_load <= 1'b1;
                end
                SAVE_R, SAVE_I: begin
                    sel_reg_dst        <= (state == SAVE_R) ? REGDST_RD : REGDST_RT;
                    sel_mux_mem_to_reg <= MEMTOREG_ALUOUT;
                    regwrite           <= (exc_cause != EXC_OVERFLOW); // Trap cancels write
                end
                BRANCH: begin
                    sel_alusrca   <= 1'b1;
                    sel_alusrcb   <= SRCB_B;
                    sel_aluop     <= ALU_CMP;
                    sel_pc_source <= PCSRC_ALUOUT;
                    pc_write_cond <= 1'b1;
                    case (instr_class)
                        CLS_BNE: sel_branchop <= BR_NE;
                        CLS_BGT: sel_branchop <= BR_GT;
                        CLS_BLE: sel_branchop <= BR_LE;
                        default: sel_branchop <= BR_EQ;
                    endcase
                end
                JUMP: begin
                    sel_pc_source <= PCSRC_JUMP;
                    pc_write      <= 1'b1;
                end
                JAL1: begin
                    sel_alusrca <= 1'b0; // Return address through the ALU
                    sel_aluop   <= ALU_PASS;
                    aluout_load <= 1'b1;
                end
                JAL2: begin
                    sel_reg_dst        <= REGDST_RA;
                    sel_mux_mem_to_reg <= MEMTOREG_ALUOUT;
                    regwrite           <= 1'b1;
                end
                JR1: begin
                    sel_alusrca <= 1'b1;
                    sel_aluop   <= ALU_PASS;
                end
                JR2: begin
                    sel_pc_source <= PCSRC_ALU;
                    pc_write      <= 1'b1;
                end
                MUL_START: mult_control <= 1'b1;
                DIV_START: div_control  <= 1'b1;
                MUL_DONE, DIV_DONE: begin
                    sel_mux_hi <= (state == MUL_DONE);
                    sel_mux_lo <= (state == MUL_DONE);
                    hilo_load  <= 1'b1;
                end
                MFHI, MFLO: begin
                    sel_reg_dst        <= REGDST_RD;
                    sel_mux_mem_to_reg <= (state == MFHI) ? MEMTOREG_HI : MEMTOREG_LO;
                    regwrite           <= 1'b1;
                end
                EXC_SAVE: begin
                    // EPC gets PC - 4
                    sel_alusrca <= 1'b0;
                    sel_alusrcb <= SRCB_FOUR;
                    sel_aluop   <= ALU_SUB;
                    epc_load    <= 1'b1;
                end
                EXC_ADDR: begin
                    case (exc_cause)
                        EXC_OVERFLOW: sel_mux_iord <= IORD_VEC_OVERFLOW;
                        EXC_DIVZERO:  sel_mux_iord <= IORD_VEC_DIVZERO;
                        default:      sel_mux_iord <= IORD_VEC_OPCODE;
                    endcase
                end
                EXC_LOAD: begin
                    mdr_load      <= 1'b1;
                    sel_pc_source <= PCSRC_EXC;
                end
                EXC_JUMP: pc_write <= 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// File: design/control_unit.sv
module control_unit
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [OP_WIDTH-1:0]    op,
    input  logic [FUNCT_WIDTH-1:0] funct,
    input  logic                   overflow,
    input  logic                   mult_stop,
    input  logic                   div_stop,
    input  logic                   div_zero,
    output logic                   ab_load,
    output logic                   wr,
    output logic                   regwrite,
    output logic                   sel_ir,
    output logic                   epc_load,
    output logic                   aluout_load,
    output logic                   hilo_load,
    output logic                   mdr_load,
    output logic                   pc_write_cond,
    output logic                   pc_write,
    output logic                   sel_regread,
    output logic                   sel_alusrca,
    output logic                   sel_mux_hi,
    output logic                   sel_mux_lo,
    output logic                   div_control,
    output logic                   mult_control,
    output logic [2:0]             sel_aluop,
    output logic [1:0]             sel_alusrcb,
    output logic [1:0]             sel_branchop,
    output logic [2:0]             sel_pc_source,
    output logic [2:0]             sel_mux_iord,
    output logic [2:0]             sel_reg_dst,
    output logic [3:0]             sel_mux_mem_to_reg
);

    instr_class_t instr_class;
    state_t       state;
    exc_cause_t   exc_cause;

    instr_decoder instr_decoder_inst (
        .clk         (clk),
        .reset       (reset),
        .op          (op),
        .funct       (funct),
        .instr_class (instr_class)
    );

    cycle_sequencer cycle_sequencer_inst (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .overflow    (overflow),
        .mult_stop   (mult_stop),
        .div_stop    (div_stop),
        .div_zero    (div_zero),
        .state       (state),
        .exc_cause   (exc_cause)
    );

    control_word_gen control_word_gen_inst (
        .clk                (clk),
        .reset              (reset),
        .state              (state),
        .exc_cause          (exc_cause),
        .instr_class        (instr_class),
        .ab_load            (ab_load),
        .wr                 (wr),
        .regwrite           (regwrite),
        .sel_ir             (sel_ir),
        .epc_load           (epc_load),
        .aluout_load        (aluout_load),
        .hilo_load          (hilo_load),
        .mdr_load           (mdr_load),
        .pc_write_cond      (pc_write_cond),
        .pc_write           (pc_write),
        .sel_regread        (sel_regread),
        .sel_alusrca        (sel_alusrca),
        .sel_mux_hi         (sel_mux_hi),
        .sel_mux_lo         (sel_mux_lo),
        .div_control        (div_control),
        .mult_control       (mult_control),
        .sel_aluop          (sel_aluop),
        .sel_alusrcb        (sel_alusrcb),
        .sel_branchop       (sel_branchop),
        .sel_pc_source      (sel_pc_source),
        .sel_mux_iord       (sel_mux_iord),
        .sel_reg_dst        (sel_reg_dst),
        .sel_mux_mem_to_reg (sel_mux_mem_to_reg)
    );

endmodule

// File: test/control_unit_asserts.sv
module control_unit_asserts (
    input logic clk,
    input logic reset,
    input logic mult_control,
    input logic div_control,
    input logic wr,
    input logic epc_load
);

    // Start pulses last one cycle
    mult_pulse: assert property (@(posedge clk) disable iff (reset)
        mult_control |=> !mult_control)
        else $error("mult_control high for two cycles");

    div_pulse: assert property (@(posedge clk) disable iff (reset)
        div_control |=> !div_control)
        else $error("div_control high for two cycles");

    no_mem_write: assert property (@(posedge clk) disable iff (reset) !wr)
        else $error("wr went high");

    epc_once: assert property (@(posedge clk) disable iff (reset)
        epc_load |=> !epc_load)
        else $error("epc_load held for more than one cycle");

endmodule

bind control_unit control_unit_asserts control_unit_asserts_inst (
    .clk          (clk),
    .reset        (reset),
    .mult_control (mult_control),
    .div_control  (div_control),
    .wr           (wr),
    .epc_load     (epc_load)
);

// File: test/control_unit_tb.sv
module control_unit_tb
    import isa_pkg::*;
    import ctrl_pkg::*;
();

    localparam int TIMEOUT = 50;
    // Bit positions in the enable snapshot
    localparam int EN_PCW  = 0;
    localparam int EN_PWC  = 1;
    localparam int EN_REGW = 2;
    localparam int EN_EPC  = 3;
    localparam int EN_MDR  = 4;
    localparam int EN_HILO = 5;
    localparam int EN_MULT = 6;
    localparam int EN_DIV  = 7;

    logic clk, reset, overflow, mult_stop, div_stop, div_zero;
    logic [OP_WIDTH-1:0] op;
    logic [FUNCT_WIDTH-1:0] funct;
    logic ab_load, wr, regwrite, sel_ir, epc_load, aluout_load, hilo_load, mdr_load;
    logic pc_write_cond, pc_write, sel_regread, sel_alusrca, sel_mux_hi, sel_mux_lo;
    logic div_control, mult_control;
    logic [2:0] sel_aluop, sel_pc_source, sel_mux_iord, sel_reg_dst;
    logic [1:0] sel_alusrcb, sel_branchop;
    logic [3:0] sel_mux_mem_to_reg;

    int k;            // Cycles since the last fetch pulse
    logic [7:0] seen; // Enables seen since then
    int errors = 0;
    int timeouts = 0;
    integer seed;

    control_unit control_unit_inst (.*);

    always #5 clk = ~clk;

    function automatic logic [7:0] en_vec();
        return {div_control, mult_control, hilo_load, mdr_load,
                epc_load, regwrite, pc_write_cond, pc_write};
    endfunction

    // Enables outside the snapshot
    function automatic logic [3:0] aux_en();
        return {aluout_load, sel_ir, ab_load, wr};
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
        k++;
        seen |= en_vec();
    endtask

    task automatic run_to(int target);
        while (k < target) step();
    endtask

    task automatic compare(string name, logic [31:0] act, logic [31:0] exp);
        assert (act === exp) else begin
            $display("error: time %0t %s got %0h expected %0h", $time, name, act, exp);
            errors++;
        end
    endtask

    // Waits for one enable and checks the cycle it came in
    task automatic wait_enable(int idx, string name, int exp_k);
        int n;
        logic [7:0] v;
        n = 0;
        step();
        v = en_vec();
        while (!v[idx] && n < TIMEOUT) begin
            step();
            v = en_vec();
            n++;
        end
        assert (v[idx]) else begin
            $display("timeout: %s did not go high within %0d cycles", name, TIMEOUT);
            timeouts++;
        end
        compare({name, " cycle"}, 32'(k), 32'(exp_k));
    endtask

    task automatic present_instr(logic [OP_WIDTH-1:0] op_v, logic [FUNCT_WIDTH-1:0] fn_v);
        op = op_v;
        funct = fn_v;
        k = 0;
        seen = '0;
    endtask

    task automatic expect_fetch(int exp_k);
        wait_enable(EN_PCW, "pc_write", exp_k);
        compare("sel_pc_source", 32'(sel_pc_source), 32'(PCSRC_ALU));
        compare("sel_alusrca", 32'(sel_alusrca), 32'd0);
        compare("sel_alusrcb", 32'(sel_alusrcb), 32'(SRCB_FOUR)); // PC + 4
    endtask

    // IR load, register read, then branch target
    task automatic decode_steps();
        step();
        compare("sel_ir", 32'(sel_ir), 32'd1);
        compare("sel_regread", 32'(sel_regread), 32'd0);
        step();
        compare("ab_load", 32'(ab_load), 32'd1);
        step();
        compare("aluout_load", 32'(aluout_load), 32'd1);
        compare("sel_alusrcb", 32'(sel_alusrcb), 32'(SRCB_OFFSET));
    endtask

    task automatic reset_then_fetch();
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        compare("regwrite", 32'(regwrite), 32'd1);
        compare("sel_reg_dst", 32'(sel_reg_dst), 32'(REGDST_SP));
        compare("sel_mux_mem_to_reg", 32'(sel_mux_mem_to_reg), 32'(MEMTOREG_SP_INIT));
        compare("enables", 32'(en_vec() & 8'hfb), 32'd0);
        compare("other enables", 32'(aux_en()), 32'd0);
        reset = 1'b0;
        present_instr(OP_RTYPE, FN_ADD);
        step();
        compare("enables after reset", 32'(en_vec()), 32'd0);
        compare("other enables after reset", 32'(aux_en()), 32'd0);
        expect_fetch(2);
    endtask

    task automatic alu_instr(logic [OP_WIDTH-1:0] op_v, logic [FUNCT_WIDTH-1:0] fn_v,
                             logic [2:0] aluop, logic [2:0] dst);
        logic [1:0] srcb;
        srcb = (op_v == OP_RTYPE) ? SRCB_B : SRCB_IMM; // Register or immediate operand
        present_instr(op_v, fn_v);
        decode_steps();
        run_to(5);
        compare("sel_aluop", 32'(sel_aluop), 32'(aluop));
        compare("sel_alusrca", 32'(sel_alusrca), 32'd1);
        compare("sel_alusrcb", 32'(sel_alusrcb), 32'(srcb));
        compare("aluout_load", 32'(aluout_load), 32'd1);
        wait_enable(EN_REGW, "regwrite", 6);
        compare("sel_reg_dst", 32'(sel_reg_dst), 32'(dst));
        compare("sel_mux_mem_to_reg", 32'(sel_mux_mem_to_reg), 32'(MEMTOREG_ALUOUT));
        expect_fetch(8);
    endtask

    // Common exception steps from the epc_load cycle on
    task automatic exception_tail(int epc_k, logic [2:0] iord);
        run_to(epc_k + 1);
        compare("sel_mux_iord", 32'(sel_mux_iord), 32'(iord));
        wait_enable(EN_MDR, "mdr_load", epc_k + 3);
        wait_enable(EN_PCW, "exception pc_write", epc_k + 4);
        compare("sel_pc_source", 32'(sel_pc_source), 32'(PCSRC_EXC));
        expect_fetch(epc_k + 6);
    endtask

    task automatic branch_instr(logic [OP_WIDTH-1:0] op_v, logic [1:0] cond);
        present_instr(op_v, '0);
        wait_enable(EN_PWC, "pc_write_cond", 5);
        compare("sel_branchop", 32'(sel_branchop), 32'(cond));
        compare("sel_pc_source", 32'(sel_pc_source), 32'(PCSRC_ALUOUT));
        expect_fetch(7);
    endtask

    task automatic jump_instrs();
        present_instr(OP_J, '0);
        wait_enable(EN_PCW, "jump pc_write", 5);
        compare("sel_pc_source", 32'(sel_pc_source), 32'(PCSRC_JUMP));
        expect_fetch(7);
        present_instr(OP_JAL, '0);
        wait_enable(EN_REGW, "link regwrite", 6);
        compare("sel_reg_dst", 32'(sel_reg_dst), 32'(REGDST_RA));
        compare("sel_mux_mem_to_reg", 32'(sel_mux_mem_to_reg), 32'(MEMTOREG_ALUOUT));
        wait_enable(EN_PCW, "jal pc_write", 7);
        compare("sel_pc_source", 32'(sel_pc_source), 32'(PCSRC_JUMP));
        expect_fetch(9);
        present_instr(OP_RTYPE, FN_JR);
        wait_enable(EN_PCW, "jr pc_write", 6);
        compare("sel_pc_source", 32'(sel_pc_source), 32'(PCSRC_ALU)); // Register through ALU
        expect_fetch(8);
    endtask

    task automatic muldiv_stall(logic is_div);
        int stall;
        stall = {$random(seed)} % 6 + 1; // At least one wait cycle
        present_instr(OP_RTYPE, is_div ? FN_DIV : FN_MULT);
        wait_enable(is_div ? EN_DIV : EN_MULT, "start pulse", 5);
        repeat (stall) begin
            step();
            compare("enables during wait", 32'(en_vec()), 32'd0);
            compare("other enables during wait", 32'(aux_en()), 32'd0);
        end
        if (is_div) div_stop = 1'b1;
        else mult_stop = 1'b1;
        wait_enable(EN_HILO, "hilo_load", 7 + stall);
        div_stop = 1'b0;
        mult_stop = 1'b0;
        compare("sel_mux_hi", 32'(sel_mux_hi), 32'(!is_div));
        compare("sel_mux_lo", 32'(sel_mux_lo), 32'(!is_div));
        expect_fetch(9 + stall);
    endtask

    task automatic move_from_hilo(logic [FUNCT_WIDTH-1:0] fn_v, logic [3:0] src);
        present_instr(OP_RTYPE, fn_v);
        wait_enable(EN_REGW, "regwrite", 5);
        compare("sel_reg_dst", 32'(sel_reg_dst), 32'(REGDST_RD));
        compare("sel_mux_mem_to_reg", 32'(sel_mux_mem_to_reg), 32'(src));
        expect_fetch(7);
    endtask

    task automatic exception_entries();
        int stall;
        // ADDI overflow cancels the write
        present_instr(OP_ADDI, '0);
        overflow = 1'b1;
        wait_enable(EN_EPC, "epc_load", 7);
        overflow = 1'b0;
        compare("regwrite seen", 32'(seen[EN_REGW]), 32'd0);
        exception_tail(7, IORD_VEC_OVERFLOW);
        overflow = 1'b1;
        alu_instr(OP_ADDIU, '0, ALU_ADD, REGDST_RT);
        overflow = 1'b0;
        present_instr(6'h3f, '0);
        wait_enable(EN_EPC, "epc_load", 5);
        exception_tail(5, IORD_VEC_OPCODE);
        stall = {$random(seed)} % 6;
        present_instr(OP_RTYPE, FN_DIV);
        wait_enable(EN_DIV, "div_control", 5);
        repeat (stall) step();
        div_zero = 1'b1;
        div_stop = 1'b1; // Divide by zero wins over stop
        wait_enable(EN_EPC, "epc_load", 7 + stall);
        div_zero = 1'b0;
        div_stop = 1'b0;
        compare("hilo_load seen", 32'(seen[EN_HILO]), 32'd0);
        exception_tail(7 + stall, IORD_VEC_DIVZERO);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        op = '0;
        funct = '0;
        overflow = 1'b0;
        mult_stop = 1'b0;
        div_stop = 1'b0;
        div_zero = 1'b0;
        seed = 32'h49fd_61e4;
        k = 0;
        seen = '0;
        reset_then_fetch();
        alu_instr(OP_RTYPE, FN_ADD, ALU_ADD, REGDST_RD);
        alu_instr(OP_RTYPE, FN_SUB, ALU_SUB, REGDST_RD);
        alu_instr(OP_RTYPE, FN_AND, ALU_AND, REGDST_RD);
        alu_instr(OP_ADDI, '0, ALU_ADD, REGDST_RT);
        alu_instr(OP_ADDIU, '0, ALU_ADD, REGDST_RT);
        branch_instr(OP_BEQ, BR_EQ);
        branch_instr(OP_BNE, BR_NE);
        branch_instr(OP_BGT, BR_GT);
        branch_instr(OP_BLE, BR_LE);
        jump_instrs();
        muldiv_stall(1'b0);
        muldiv_stall(1'b1);
        move_from_hilo(FN_MFHI, MEMTOREG_HI);
        move_from_hilo(FN_MFLO, MEMTOREG_LO);
        exception_entries();
        $display("done: %0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
design/isa_pkg.sv
design/ctrl_pkg.sv
design/instr_decoder.sv
design/cycle_sequencer.sv
design/control_word_gen.sv
design/control_unit.sv
test/control_unit_asserts.sv
test/control_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module control_unit_tb -o control_unit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/control_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi
